/* compile.f */
+incdir+rtl
rtl/fabric_pkg.sv
rtl/clb_cell.sv
rtl/clb_routing.sv
rtl/fabric_config_apb.sv
rtl/logic_fabric_top.sv
tb/tb_clk_gen.sv
tb/fabric_checker.sv
tb/fabric_assertions.sv
tb/logic_fabric_tb.sv

/* rtl/clb_cell.sv */
`timescale 1ns/1ps
`default_nettype none

module clb_cell
(
   input  logic                       KLK,
   input  logic                       arst_n,
   input  fabric_pkg::clb_pins_t      pins,
   input  fabric_pkg::clb_logic_cfg_t logic_cfg,
   input  fabric_pkg::clb_route_cfg_t route_cfg,
   output logic                       q,
   output logic                       x,
   output logic                       y
);
   import fabric_pkg::*;

   logic       dq1;
   logic       dq2;
   logic [3:0] idx_f;
   logic [3:0] idx_g;
   logic       f;
   logic       g;
   logic       sr_set;
   logic       sr_clr;
   logic       clk_en;

   // Select 00 takes in0, 01 takes in1, anything else in2
   function automatic logic mux3
   (
      input mux_sel_t sel,
      input logic     in0,
      input logic     in1,
      input logic     in2
   );
      logic val;
      case (sel)
         2'b00:   val = in0;
         2'b01:   val = in1;
         default: val = in2;
      endcase
      return val;
   endfunction

   // ##################################################
   // Truth table
   // ##################################################
   assign dq1 = logic_cfg.dq_sel_f ? q : pins.d;
   assign dq2 = logic_cfg.dq_sel_g ? q : pins.d;

   always_comb
   begin
      case (logic_cfg.comb_mode)
         TABLE4:
         begin
            idx_f = {pins.a, pins.b, pins.c, dq1};
            idx_g = idx_f;
         end
         SPLIT3:
         begin
            // Lower half drives F, upper half drives G
            idx_f = {1'b0,
                     logic_cfg.steer_f[0] ? pins.b : pins.a,
                     logic_cfg.steer_f[1] ? pins.c : pins.b,
                     logic_cfg.steer_f[2] ? dq1    : pins.c};
            idx_g = {1'b1,
                     logic_cfg.steer_g[0] ? pins.b : pins.a,
                     logic_cfg.steer_g[1] ? pins.c : pins.b,
                     logic_cfg.steer_g[2] ? dq2    : pins.c};
         end
         default:
         begin
            // B picks the half, and with it DQ1 or DQ2
            idx_f = pins.b ? {1'b1, pins.a, pins.c, dq2} : {1'b0, pins.a, pins.c, dq1};
            idx_g = idx_f;
         end
      endcase
   end

   assign f = logic_cfg.truth_table[idx_f];
   assign g = logic_cfg.truth_table[idx_g];

   // ##################################################
   // Storage element and output selectors
   // ##################################################
   assign sr_set = mux3(route_cfg.set_sel,    pins.a, f,      1'b0);
   assign sr_clr = mux3(route_cfg.reset_sel,  pins.d, g,      1'b0);
   assign clk_en = mux3(route_cfg.enable_sel, g,      pins.c, pins.k);

   assign x = mux3(route_cfg.x_sel, f, g, q);
   assign y = mux3(route_cfg.y_sel, q, g, f);

   always_ff @(posedge KLK or negedge arst_n)
   begin
      if (!arst_n)
         q <= 1'b0;
      else if (clk_en)
      begin
         // Reset wins over set
         if (sr_clr)
            q <= 1'b0;
         else if (sr_set)
            q <= 1'b1;
         else
            q <= f;
      end
   end

endmodule

`default_nettype wire

/* rtl/clb_routing.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fabric_defines.svh"

module clb_routing
(
   input  fabric_pkg::pin_vec_t           pins_in,
   input  fabric_pkg::clb_vec_t           q_in,
   input  fabric_pkg::clb_route_cfg_arr_t route_cfg,
   output fabric_pkg::clb_pins_arr_t      clb_pins
);
   import fabric_pkg::*;

   // 0..7 pins, 8..11 block Q, 13 constant 1, everything else 0
   function automatic logic pick_src
   (
      input src_sel_t sel,
      input pin_vec_t pins,
      input clb_vec_t q
   );
      logic val;
      if (!sel[3])
         val = pins[sel[2:0]];
      else if (sel[2] == 1'b0)
         val = q[sel[1:0]];
      else if (sel == 4'd13)
         val = 1'b1;
      else
         val = 1'b0;
      return val;
   endfunction

   always_comb
   begin
      for (int i = 0; i < `FABRIC_NUM_CLB; i++)
      begin
         clb_pins[i].a = pick_src(route_cfg[i].src_a, pins_in, q_in);
         clb_pins[i].b = pick_src(route_cfg[i].src_b, pins_in, q_in);
         clb_pins[i].c = pick_src(route_cfg[i].src_c, pins_in, q_in);
         clb_pins[i].d = pick_src(route_cfg[i].src_d, pins_in, q_in);
         clb_pins[i].k = pick_src(route_cfg[i].src_k, pins_in, q_in);
      end
   end

endmodule

`default_nettype wire

/* rtl/fabric_config_apb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fabric_defines.svh"

module fabric_config_apb
(
   input  logic                           KLK,
   input  logic                           arst_n,
   input  logic                           psel,
   input  logic                           penable,
   input  logic                           pwrite,
   input  fabric_pkg::apb_addr_t          paddr,
   input  fabric_pkg::apb_data_t          pwdata,
   output fabric_pkg::apb_data_t          prdata,
   output logic                           pready,
   output logic                           pslverr,
   output fabric_pkg::clb_logic_cfg_arr_t logic_cfg,
   output fabric_pkg::clb_route_cfg_arr_t route_cfg
);
   import fabric_pkg::*;

   localparam int        CLB_IDX_W = $clog2(`FABRIC_NUM_CLB);
   localparam int        LOGIC_W   = $bits(clb_logic_cfg_t);
   localparam int        ROUTE_W   = $bits(clb_route_cfg_t);
   localparam apb_addr_t MAP_END   = apb_addr_t'(8 * `FABRIC_NUM_CLB);
   localparam apb_data_t CFG0_RST  = `FABRIC_CFG0_RST;
   localparam apb_data_t CFG1_RST  = `FABRIC_CFG1_RST;

   logic                 setup;
   logic                 wr_en;
   logic                 hit;
   logic [CLB_IDX_W-1:0] blk;
   apb_data_t            rd_data;

   // Two words per block, eight bytes apart
   assign hit   = (paddr[1:0] == 2'b00) && (paddr < MAP_END);
   assign blk   = paddr[3 +: CLB_IDX_W];
   assign setup = psel && !penable;
   assign wr_en = psel && penable && pwrite && hit;

   assign pready = 1'b1;

   // ##################################################
   // Configuration registers
   // ##################################################
   always_ff @(posedge KLK or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < `FABRIC_NUM_CLB; i++)
         begin
            logic_cfg[i] <= CFG0_RST[LOGIC_W-1:0];
            route_cfg[i] <= CFG1_RST[ROUTE_W-1:0];
         end
      end
      else if (wr_en)
      begin
         if (paddr[2])
            route_cfg[blk] <= pwdata[ROUTE_W-1:0];
         else
            logic_cfg[blk] <= pwdata[LOGIC_W-1:0];
      end
   end

   // ##################################################
   // Read path
   // ##################################################
   always_comb
   begin
      rd_data = '0;
      if (hit)
      begin
         if (paddr[2])
            rd_data[ROUTE_W-1:0] = route_cfg[blk];
         else
            rd_data[LOGIC_W-1:0] = logic_cfg[blk];
      end
   end

   // Captured in setup so data and error are valid through the access phase
   always_ff @(posedge KLK or negedge arst_n)
   begin
      if (!arst_n)
      begin
         prdata  <= '0;
         pslverr <= 1'b0;
      end
      else if (setup)
      begin
         prdata  <= pwrite ? '0 : rd_data;
         pslverr <= !hit;
      end
      else
      begin
         prdata  <= '0;
         pslverr <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* rtl/fabric_defines.svh */
`ifndef FABRIC_DEFINES_SVH
`define FABRIC_DEFINES_SVH

// ##################################################
// Fabric dimensions
// ##################################################
`define FABRIC_NUM_CLB   4
`define FABRIC_NUM_PINS  8
`define FABRIC_ADDR_W    8

// ##################################################
// Power-up configuration of every block
// ##################################################
// Table 0x0116, TABLE4, F steering 000, G steering 111, D on both DQ muxes
`define FABRIC_CFG0_RST  32'h0004_58E0
// Set/reset constant 0, enable on K, X = F, Y = Q, all sources constant 0
`define FABRIC_CFG1_RST  32'h2A0C_CCCC

`endif

/* rtl/fabric_pkg.sv */
`default_nettype none

`include "fabric_defines.svh"

package fabric_pkg;

   typedef logic [15:0]                     truth_table_t;
   typedef logic [3:0]                      src_sel_t;
   typedef logic [1:0]                      mux_sel_t;
   typedef logic [`FABRIC_NUM_PINS-1:0]     pin_vec_t;
   typedef logic [`FABRIC_NUM_CLB-1:0]      clb_vec_t;
   typedef logic [`FABRIC_ADDR_W-1:0]       apb_addr_t;
   typedef logic [31:0]                     apb_data_t;

   typedef enum logic [1:0]
   {
      TABLE4 = 2'd0,
      SPLIT3 = 2'd1,
      BMUX   = 2'd2
   } comb_mode_t;

   // APB word 0, bits [25:0]
   typedef struct packed
   {
      truth_table_t truth_table;
      comb_mode_t   comb_mode;
      logic [2:0]   steer_g;
      logic [2:0]   steer_f;
      logic         dq_sel_g;
      logic         dq_sel_f;
   } clb_logic_cfg_t;

   // APB word 1, bits [29:0]
   typedef struct packed
   {
      mux_sel_t set_sel;
      mux_sel_t enable_sel;
      mux_sel_t reset_sel;
      mux_sel_t x_sel;
      mux_sel_t y_sel;
      src_sel_t src_a;
      src_sel_t src_b;
      src_sel_t src_c;
      src_sel_t src_d;
      src_sel_t src_k;
   } clb_route_cfg_t;

   typedef struct packed
   {
      logic a;
      logic b;
      logic c;
      logic d;
      logic k;
   } clb_pins_t;

   typedef clb_logic_cfg_t [`FABRIC_NUM_CLB-1:0] clb_logic_cfg_arr_t;
   typedef clb_route_cfg_t [`FABRIC_NUM_CLB-1:0] clb_route_cfg_arr_t;
   typedef clb_pins_t      [`FABRIC_NUM_CLB-1:0] clb_pins_arr_t;

endpackage

`default_nettype wire

/* rtl/logic_fabric_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fabric_defines.svh"

module logic_fabric_top
(
   input  logic                  KLK,
   input  logic                  arst_n,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  fabric_pkg::apb_addr_t paddr,
   input  fabric_pkg::apb_data_t pwdata,
   output fabric_pkg::apb_data_t prdata,
   output logic                  pready,
   output logic                  pslverr,
   input  fabric_pkg::pin_vec_t  pins_in,
   output fabric_pkg::clb_vec_t  fabric_x,
   output fabric_pkg::clb_vec_t  fabric_y
);
   import fabric_pkg::*;

   clb_logic_cfg_arr_t logic_cfg;
   clb_route_cfg_arr_t route_cfg;
   clb_pins_arr_t      clb_pins;
   clb_vec_t           q_vec;

   fabric_config_apb u_cfg
   (
      .KLK       (KLK),
      .arst_n    (arst_n),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .logic_cfg (logic_cfg),
      .route_cfg (route_cfg)
   );

   // Only registered Q feeds back into the routing
   clb_routing u_route
   (
      .pins_in   (pins_in),
      .q_in      (q_vec),
      .route_cfg (route_cfg),
      .clb_pins  (clb_pins)
   );

   for (genvar i = 0; i < `FABRIC_NUM_CLB; i++)
   begin : g_clb
      clb_cell u_clb
      (
         .KLK       (KLK),
         .arst_n    (arst_n),
         .pins      (clb_pins[i]),
         .logic_cfg (logic_cfg[i]),
         .route_cfg (route_cfg[i]),
         .q         (q_vec[i]),
         .x         (fabric_x[i]),
         .y         (fabric_y[i])
      );
   end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module logic_fabric_tb -f compile.f -o sim_fabric
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_fabric > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
   echo "simulation reported failures"
   exit 1
fi

exit 0

/* tb/fabric_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module fabric_assertions
(
   input logic                  KLK,
   input logic                  arst_n,
   input logic                  psel,
   input logic                  penable,
   input logic                  pready,
   input logic                  pslverr,
   input fabric_pkg::apb_data_t prdata
);

   // Error response only inside an access phase
   a_slverr_access: assert property (@(posedge KLK) disable iff (!arst_n)
                                     pslverr |-> (psel && penable))
      else $error("pslverr was high outside an APB access phase");

   a_no_wait: assert property (@(posedge KLK) pready)
      else $error("pready went low on a zero wait state slave");

   a_rd_reset: assert property (@(posedge KLK) !arst_n |-> (prdata == '0))
      else $error("prdata was not zero during reset");

endmodule

bind fabric_config_apb fabric_assertions u_apb_checks
(
   .KLK     (KLK),
   .arst_n  (arst_n),
   .psel    (psel),
   .penable (penable),
   .pready  (pready),
   .pslverr (pslverr),
   .prdata  (prdata)
);

`default_nettype wire

/* tb/fabric_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fabric_defines.svh"

module fabric_checker
(
   input  logic                  KLK,
   input  logic                  arst_n,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  fabric_pkg::apb_addr_t paddr,
   input  fabric_pkg::apb_data_t pwdata,
   input  fabric_pkg::apb_data_t prdata,
   input  logic                  pready,
   input  logic                  pslverr,
   input  fabric_pkg::pin_vec_t  pins_in,
   input  fabric_pkg::clb_vec_t  fabric_x,
   input  fabric_pkg::clb_vec_t  fabric_y,
   input  logic [8*12-1:0]       test_name,
   input  logic                  exp_rd_valid,
   input  fabric_pkg::apb_data_t exp_rdata,
   output int                    xy_errs,
   output int                    apb_errs,
   output int                    checks
);
   import fabric_pkg::*;

   apb_data_t word0 [`FABRIC_NUM_CLB];
   apb_data_t word1 [`FABRIC_NUM_CLB];
   clb_vec_t  q_model;
   clb_vec_t  q_next;
   clb_vec_t  exp_x;
   clb_vec_t  exp_y;
   logic      wr_pend;
   apb_addr_t wr_addr;
   apb_data_t wr_data;
   apb_data_t exp_rd;
   logic      mapped;

   function automatic logic choose3(input logic [1:0] sel, input logic i0, i1, i2);
      if (sel == 2'd0)
         return i0;
      if (sel == 2'd1)
         return i1;
      return i2;
   endfunction

   function automatic logic route_src(input logic [3:0] s, input pin_vec_t p, input clb_vec_t qv);
      if (s < 4'd8)
         return p[s[2:0]];
      if (s < 4'd12)
         return qv[s[1:0]];
      return s == 4'd13;
   endfunction

   // Models one block from its two words and returns {x, y, next q}
   function automatic logic [2:0] model_block
   (
      input apb_data_t w0,
      input apb_data_t w1,
      input pin_vec_t  p,
      input clb_vec_t  qv,
      input logic      qn
   );
      logic [15:0] tt;
      logic        a, b, c, d, k, dq1, dq2, f, g, s, r, en;
      tt  = w0[25:10];
      a   = route_src(w1[19:16], p, qv);
      b   = route_src(w1[15:12], p, qv);
      c   = route_src(w1[11:8], p, qv);
      d   = route_src(w1[7:4], p, qv);
      k   = route_src(w1[3:0], p, qv);
      dq1 = w0[0] ? qn : d;
      dq2 = w0[1] ? qn : d;
      case (w0[9:8])
         2'd0:
         begin
            f = tt[{a, b, c, dq1}];
            g = f;
         end
         2'd1:
         begin
            f = tt[{1'b0, w0[2] ? b : a, w0[3] ? c : b, w0[4] ? dq1 : c}];
            g = tt[{1'b1, w0[5] ? b : a, w0[6] ? c : b, w0[7] ? dq2 : c}];
         end
         default:
         begin
            f = b ? tt[{1'b1, a, c, dq2}] : tt[{1'b0, a, c, dq1}];
            g = f;
         end
      endcase
      s  = choose3(w1[29:28], a, f, 1'b0);
      en = choose3(w1[27:26], g, c, k);
      r  = choose3(w1[25:24], d, g, 1'b0);
      return {choose3(w1[23:22], f, g, qn), choose3(w1[21:20], qn, g, f),
              en ? (!r && (s || f)) : qn};
   endfunction

   assign mapped = (paddr[1:0] == 2'b00) && (paddr < apb_addr_t'(8 * `FABRIC_NUM_CLB));

   // ##################################################
   // Compare in mid cycle while everything is settled
   // ##################################################
   always @(negedge KLK)
   begin
      if (arst_n)
      begin
         for (int n = 0; n < `FABRIC_NUM_CLB; n++)
            {exp_x[n], exp_y[n], q_next[n]} =
               model_block(word0[n], word1[n], pins_in, q_model, q_model[n]);
         checks++;
         if (fabric_x !== exp_x)
         begin
            xy_errs++;
            $display("mismatch %s: fabric_x expected %h actual %h", test_name, exp_x, fabric_x);
         end
         if (fabric_y !== exp_y)
         begin
            xy_errs++;
            $display("mismatch %s: fabric_y expected %h actual %h", test_name, exp_y, fabric_y);
         end
         if (pready !== 1'b1)
         begin
            apb_errs++;
            $display("mismatch %s: pready expected 1 actual %b", test_name, pready);
         end
         if (pslverr !== (psel && penable && !mapped))
         begin
            apb_errs++;
            $display("mismatch %s: pslverr expected %b actual %b", test_name,
                     psel && penable && !mapped, pslverr);
         end
         if (psel && penable && !pwrite)
         begin
            exp_rd = !mapped ? '0 : (paddr[2] ? word1[paddr[4:3]] : word0[paddr[4:3]]);
            if (prdata !== exp_rd)
            begin
               apb_errs++;
               $display("mismatch %s: prdata expected %h actual %h", test_name, exp_rd, prdata);
            end
            if (exp_rd_valid && prdata !== exp_rdata)
            begin
               apb_errs++;
               $display("mismatch %s: prdata expected %h actual %h", test_name, exp_rdata,
                        prdata);
            end
         end
         wr_pend = psel && penable && pwrite && mapped;
         wr_addr = paddr;
         wr_data = pwdata;
      end
   end

   // Model state moves on the same edge as the DUT
   always @(posedge KLK or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int n = 0; n < `FABRIC_NUM_CLB; n++)
         begin
            word0[n] <= `FABRIC_CFG0_RST;
            word1[n] <= `FABRIC_CFG1_RST;
         end
         q_model <= '0;
      end
      else
      begin
         q_model <= q_next;
         if (wr_pend && wr_addr[2])
            word1[wr_addr[4:3]] <= wr_data & 32'h3FFF_FFFF;
         else if (wr_pend)
            word0[wr_addr[4:3]] <= wr_data & 32'h03FF_FFFF;
      end
   end

endmodule

`default_nettype wire

/* tb/logic_fabric_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fabric_defines.svh"

module logic_fabric_tb;
   import fabric_pkg::*;

   localparam logic [1:0] WR  = 2'd0;
   localparam logic [1:0] RD  = 2'd1;
   localparam logic [1:0] RUN = 2'd2;
   localparam logic [1:0] RND = 2'd3;

   // RUN holds data[7:0] on the pins, RND draws fresh pins every cycle
   typedef struct packed
   {
      logic [1:0]      kind;
      logic [8*12-1:0] name;
      apb_addr_t       addr;
      apb_data_t       data;
      logic [7:0]      cycles;
   } row_t;

   logic            KLK;
   logic            arst_n;
   logic            psel;
   logic            penable;
   logic            pwrite;
   apb_addr_t       paddr;
   apb_data_t       pwdata;
   apb_data_t       prdata;
   logic            pready;
   logic            pslverr;
   pin_vec_t        pins_in;
   clb_vec_t        fabric_x;
   clb_vec_t        fabric_y;
   logic [8*12-1:0] cur_name;
   logic            exp_rd_valid;
   apb_data_t       exp_rdata;
   int              xy_errs;
   int              apb_errs;
   int              checks;
   row_t            rows [$];
   int              n_rows = 0;
   logic [15:0]     lfsr;

   tb_clk_gen u_clk
   (
      .KLK    (KLK),
      .arst_n (arst_n)
   );

   logic_fabric_top DUT
   (
      .KLK      (KLK),
      .arst_n   (arst_n),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr),
      .pins_in  (pins_in),
      .fabric_x (fabric_x),
      .fabric_y (fabric_y)
   );

   fabric_checker u_chk
   (
      .KLK          (KLK),
      .arst_n       (arst_n),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .pins_in      (pins_in),
      .fabric_x     (fabric_x),
      .fabric_y     (fabric_y),
      .test_name    (cur_name),
      .exp_rd_valid (exp_rd_valid),
      .exp_rdata    (exp_rdata),
      .xy_errs      (xy_errs),
      .apb_errs     (apb_errs),
      .checks       (checks)
   );

   // ##################################################
   // Word builders, APB driver and pin stimulus
   // ##################################################
   function automatic apb_data_t logic_word
   (
      input logic [15:0] tt,
      input logic [1:0]  mode,
      input logic [2:0]  steer_g,
      input logic [2:0]  steer_f,
      input logic [1:0]  dq
   );
      return {6'd0, tt, mode, steer_g, steer_f, dq};
   endfunction

   // sel is {set, enable, reset, x, y}, src is {a, b, c, d, k}
   function automatic apb_data_t route_word(input logic [9:0] sel, input logic [19:0] src);
      return {2'd0, sel, src};
   endfunction

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task add_row
   (
      input logic [1:0]      kind,
      input logic [8*12-1:0] name,
      input apb_addr_t       addr,
      input apb_data_t       data,
      input logic [7:0]      cycles
   );
      rows.push_back(row_t'{kind, name, addr, data, cycles});
   endtask

   task next_pins(output pin_vec_t v);
      for (int b = 0; b < `FABRIC_NUM_PINS; b++)
      begin
         v[b] = lfsr[0];
         lfsr = lfsr_step(lfsr);
      end
   endtask

   task apb_xfer(input logic wr, input row_t r);
      @(posedge KLK);
      psel         <= 1'b1;
      penable      <= 1'b0;
      pwrite       <= wr;
      paddr        <= r.addr;
      pwdata       <= wr ? r.data : '0;
      exp_rd_valid <= !wr;
      exp_rdata    <= r.data;
      @(posedge KLK);
      penable <= 1'b1;
      @(posedge KLK);
      while (!pready)
         @(posedge KLK);
      psel         <= 1'b0;
      penable      <= 1'b0;
      exp_rd_valid <= 1'b0;
   endtask

   task drive_pins(input row_t r);
      pin_vec_t v;
      for (int i = 0; i < int'(r.cycles); i++)
      begin
         @(posedge KLK);
         if (r.kind == RND)
            next_pins(v);
         else
            v = r.data[7:0];
         pins_in <= v;
      end
   endtask

   // ##################################################
   // Test table and main sequence
   // ##################################################
   initial
   begin
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      pins_in      = '0;
      cur_name     = "reset";
      exp_rd_valid = 1'b0;
      exp_rdata    = '0;
      lfsr         = 16'd14282;

      // Power-up words built from the reference cell defaults
      add_row(RD, "rst_w0_b0", 8'h00,
              logic_word(16'h0116, 2'd0, 3'b111, 3'b000, 2'b00), 8'd0);
      add_row(RD, "rst_w1_b3", 8'h1C,
              route_word({2'd2, 2'd2, 2'd2, 2'd0, 2'd0}, {5{4'd12}}), 8'd0);
      add_row(RND, "rst_outputs", 8'h00, 32'h0, 8'd6);

      // Each block reads four neighbouring pins and shows F on x and G on y
      for (int n = 0; n < `FABRIC_NUM_CLB; n++)
      begin
         add_row(WR, "t4_cfg", apb_addr_t'(8 * n),
                 logic_word(16'hA5C3 ^ (16'h3C1F << n), 2'd0, 3'd0, 3'd0, 2'd0), 8'd0);
         add_row(WR, "t4_route", apb_addr_t'(8 * n + 4),
                 route_word({2'd2, 2'd2, 2'd2, 2'd0, 2'd1},
                            {4'(n), 4'((n + 1) % 8), 4'((n + 2) % 8), 4'((n + 3) % 8), 4'd12}),
                 8'd0);
      end
      add_row(RND, "table4", 8'h00, 32'h0, 8'd16);

      add_row(WR, "s3_cfg0", 8'h00, logic_word(16'h6C93, 2'd1, 3'b010, 3'b101, 2'b10), 8'd0);
      add_row(WR, "s3_cfg1", 8'h08, logic_word(16'h1E78, 2'd1, 3'b101, 3'b011, 2'b00), 8'd0);
      add_row(RND, "split3", 8'h00, 32'h0, 8'd16);

      // Block 3 clocks F into Q from pin 7 so DQ2 sees a live Q
      add_row(WR, "bm_cfg2", 8'h10, logic_word(16'hD2B4, 2'd2, 3'd0, 3'd0, 2'b00), 8'd0);
      add_row(WR, "bm_cfg3", 8'h18, logic_word(16'h47E1, 2'd2, 3'd0, 3'd0, 2'b10), 8'd0);
      add_row(WR, "bm_route3", 8'h1C,
              route_word({2'd2, 2'd2, 2'd2, 2'd0, 2'd1}, {4'd3, 4'd4, 4'd5, 4'd6, 4'd7}), 8'd0);
      add_row(RND, "bmux", 8'h00, 32'h0, 8'd16);

      // Pin 0 sets, pin 1 enables, pin 2 resets block 3; block 0 shows Q3 on x
      add_row(WR, "sr_cfg", 8'h18, logic_word(16'h0000, 2'd0, 3'd0, 3'd0, 2'd0), 8'd0);
      add_row(WR, "sr_route", 8'h1C,
              route_word({2'd0, 2'd1, 2'd0, 2'd2, 2'd0}, {4'd0, 4'd12, 4'd1, 4'd2, 4'd12}), 8'd0);
      add_row(WR, "sr_watch", 8'h00, logic_word(16'hFF00, 2'd0, 3'd0, 3'd0, 2'd0), 8'd0);
      add_row(WR, "sr_watch_rt", 8'h04,
              route_word({2'd2, 2'd2, 2'd2, 2'd0, 2'd0}, {4'd11, 4'd12, 4'd12, 4'd12, 4'd12}),
              8'd0);
      add_row(RUN, "sr_clear", 8'h00, 32'h6, 8'd2);
      add_row(RUN, "sr_set", 8'h00, 32'h3, 8'd1);
      add_row(RUN, "sr_hold", 8'h00, 32'h0, 8'd3);
      add_row(RUN, "sr_rst_wins", 8'h00, 32'h7, 8'd1);
      add_row(RUN, "sr_set2", 8'h00, 32'h3, 8'd1);
      add_row(RUN, "sr_take_f", 8'h00, 32'h2, 8'd2);

      add_row(WR, "err_wr_hole", 8'h40, 32'hFFFF_FFFF, 8'd0);
      add_row(WR, "err_wr_align", 8'h02, 32'hFFFF_FFFF, 8'd0);
      add_row(RD, "err_rd_hole", 8'h20, 32'h0, 8'd0);
      add_row(RD, "err_rd_align", 8'h05, 32'h0, 8'd0);
      add_row(RD, "err_keep_b0", 8'h00,
              logic_word(16'hFF00, 2'd0, 3'd0, 3'd0, 2'd0), 8'd0);
      add_row(RD, "err_keep_b3", 8'h1C,
              route_word({2'd0, 2'd1, 2'd0, 2'd2, 2'd0}, {4'd0, 4'd12, 4'd1, 4'd2, 4'd12}), 8'd0);
      add_row(RND, "after_err", 8'h00, 32'h0, 8'd8);
      n_rows = rows.size();

      wait (arst_n);
      @(posedge KLK);
      foreach (rows[i])
      begin
         @(posedge KLK);
         cur_name <= rows[i].name;
         case (rows[i].kind)
            WR:      apb_xfer(1'b1, rows[i]);
            RD:      apb_xfer(1'b0, rows[i]);
            default: drive_pins(rows[i]);
         endcase
      end
      repeat (2)
         @(posedge KLK);

      $display("closing: %0d checks, %0d fabric output errors, %0d apb errors",
               checks, xy_errs, apb_errs);
      if (xy_errs == 0 && apb_errs == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

   // Watchdog allows 40 cycles per row plus reset
   initial
   begin
      wait (n_rows > 0);
      repeat (n_rows * 40 + 8)
         @(posedge KLK);
      $display("timeout: the %0d table rows did not complete in time", n_rows);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen
(
   output logic KLK,
   output logic arst_n
);
   localparam int RESET_CYCLES = 8;

   // 100 ns period
   initial
   begin
      KLK = 1'b0;
      forever
         #50 KLK = ~KLK;
   end

   initial
   begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES)
         @(posedge KLK);
      arst_n <= 1'b1;
   end

endmodule

`default_nettype wire
